// ==== verilog/dacPkg.sv ====
// DAC sample formats: linear samples, stereo pairs, float words and serial framing

package dacPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sample types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic signed [15:0] linSample_t;    // Two's complement linear sample

    typedef struct packed {
        linSample_t left;                       // Upper half, sent first
        linSample_t right;                      // Lower half, sent second
    } stereoPair_t;

    // YM3012 style float word
    typedef struct packed {
        logic [9:0] man;                        // Signed mantissa
        logic [2:0] exp;                        // 1 = smallest step, 7 = largest
    } floatWord_t;

    ////////////////////////////////////////////////////////////////////////////
    // Serial link framing
    ////////////////////////////////////////////////////////////////////////////

    localparam int slotPad   = 3;               // Leading zeros in each slot
    localparam int slotBits  = 16;              // Pad + mantissa + exponent
    localparam int frameBits = 32;              // Left slot then right slot

endpackage

// ==== verilog/busPkg.sv ====
// AXI4-Lite bus types, sample register map and write-data decoding for the DAC port

package busPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Channel types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [3:0] axiAddr_t;              // Byte address of a register
    typedef logic [1:0] axiResp_t;

    localparam axiResp_t respOkay   = 2'b00;
    localparam axiResp_t respSlvErr = 2'b10;

    // Master to slave
    typedef struct packed {
        axiAddr_t    awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic        wvalid;
        logic        bready;
        axiAddr_t    araddr;
        logic        arvalid;
        logic        rready;
    } axiLiteReq_t;

    // Slave to master
    typedef struct packed {
        logic        awready;
        logic        wready;
        axiResp_t    bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        axiResp_t    rresp;
        logic        rvalid;
    } axiLiteRsp_t;

    ////////////////////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////////////////////

    localparam axiAddr_t addrSample = 4'h0;     // Write only, pushes one pair
    localparam axiAddr_t addrCtrl   = 4'h4;     // Read and write
    localparam axiAddr_t addrStatus = 4'h8;     // Read only

    typedef struct packed {
        logic [30:0] pad;                       // Reads as zero
        logic        mute;
    } ctrlWord_t;

    typedef struct packed {
        logic [21:0] padHi;
        logic        full;                      // Bit 9
        logic        empty;                     // Bit 8
        logic [2:0]  padLo;
        logic [4:0]  level;                     // Pairs queued
    } statusWord_t;

    // One wdata word, decoded by address
    typedef union packed {
        dacPkg::stereoPair_t pair;              // addrSample view
        ctrlWord_t           ctrl;              // addrCtrl view
    } regWord_u;

endpackage

// ==== verilog/lin2exp.sv ====
// Linear to float converter: 16-bit sample to 10-bit mantissa and 3-bit exponent

`timescale 1ns/100ps

module lin2exp (
    input  dacPkg::linSample_t lin,
    output dacPkg::floatWord_t flt
);

    logic [2:0] n;                              // Sign repeats below the MSB
    logic       run;                            // Still inside the sign run

    always_comb begin
        n   = '0;
        run = 1'b1;
        // Scan lin[14:9] downward while the bits copy the sign
        for (int i = 14; i >= 9; i--) begin
            if (run && (lin[i] == lin[15])) begin
                n = n + 1'b1;
            end else begin
                run = 1'b0;                     // First bit that differs ends the run
            end
        end
        flt.exp = 3'd7 - n;                     // Six repeats give exponent 1
        flt.man = lin[15 - n -: 10];            // Window starts at the last sign copy
    end

endmodule

// ==== verilog/sampleRegs.sv ====
// Sample register slave: AXI4-Lite writes feed the FIFO, mute control and status readback

`timescale 1ns/100ps

module sampleRegs #(
    parameter int fifoDepth = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  busPkg::axiLiteReq_t req,
    output busPkg::axiLiteRsp_t rsp,
    input  logic                full,
    input  logic                empty,
    input  logic [4:0]          level,
    output logic                push,
    output dacPkg::stereoPair_t pushData,
    output logic                mute
);

    localparam int levelBits = $clog2(fifoDepth + 1);  // Meaningful level bits

    busPkg::regWord_u    wrWord;                // wdata seen through the union
    busPkg::regWord_u    ctrlWord;
    busPkg::statusWord_t statusWord;
    logic                wrIsSample;
    logic                wrIsCtrl;
    logic                wrFire;                // AW and W accepted together
    logic                rdFire;
    logic                bvalid;
    logic                rvalid;
    busPkg::axiResp_t    bresp;
    busPkg::axiResp_t    rresp;
    logic [31:0]         rdata;
    logic [31:0]         rdWord;                // Read mux output
    busPkg::axiResp_t    rdResp;

    ////////////////////////////////////////////////////////////////////////////
    // Write channel
    ////////////////////////////////////////////////////////////////////////////

    assign wrWord     = busPkg::regWord_u'(req.wdata);
    assign wrIsSample = (req.awaddr == busPkg::addrSample);
    assign wrIsCtrl   = (req.awaddr == busPkg::addrCtrl);
    // Full FIFO stalls sample writes until a pop
    assign wrFire     = req.awvalid && req.wvalid && !bvalid && !(wrIsSample && full);
    assign push       = wrFire && wrIsSample;
    assign pushData   = wrWord.pair;

    ////////////////////////////////////////////////////////////////////////////
    // Read channel
    ////////////////////////////////////////////////////////////////////////////

    assign rdFire = req.arvalid && !rvalid;     // One read in flight

    always_comb begin
        statusWord       = '0;
        statusWord.level = 5'(level[levelBits-1:0]);
        statusWord.empty = empty;
        statusWord.full  = full;
        ctrlWord         = '0;
        ctrlWord.ctrl.mute = mute;
        rdWord = '0;
        rdResp = busPkg::respOkay;
        case (req.araddr)
            busPkg::addrSample: rdWord = '0;    // Write only, reads zero
            busPkg::addrCtrl:   rdWord = ctrlWord;
            busPkg::addrStatus: rdWord = statusWord;
            default:            rdResp = busPkg::respSlvErr;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            mute   <= 1'b0;
        end else begin
            if (wrFire) begin
                bvalid <= 1'b1;
            end else if (req.bready) begin
                bvalid <= 1'b0;                 // Held until accepted
            end
            if (rdFire) begin
                rvalid <= 1'b1;
            end else if (req.rready) begin
                rvalid <= 1'b0;
            end
            if (wrFire && wrIsCtrl) begin
                mute <= wrWord.ctrl.mute;
            end
        end
    end

    // Response payloads
    always_ff @(posedge clk) begin
        if (wrFire) begin
            bresp <= (wrIsSample || wrIsCtrl) ? busPkg::respOkay : busPkg::respSlvErr;
        end
        if (rdFire) begin
            rdata <= rdWord;
            rresp <= rdResp;
        end
    end

    always_comb begin
        rsp         = '0;
        rsp.awready = wrFire;
        rsp.wready  = wrFire;                   // Same cycle as awready
        rsp.bresp   = bresp;
        rsp.bvalid  = bvalid;
        rsp.arready = !rvalid;
        rsp.rdata   = rdata;
        rsp.rresp   = rresp;
        rsp.rvalid  = rvalid;
    end

endmodule

// ==== verilog/sampleFifo.sv ====
// Stereo pair FIFO: circular buffer with read and write pointers and a fill level

`timescale 1ns/100ps

module sampleFifo #(
    parameter int fifoDepth = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  dacPkg::stereoPair_t pushData,
    input  logic                pop,
    output dacPkg::stereoPair_t popData,
    output logic                full,
    output logic                empty,
    output logic [4:0]          level
);

    localparam int ptrBits = $clog2(fifoDepth);  // Depth is a power of two

    dacPkg::stereoPair_t mem [fifoDepth];
    logic [ptrBits-1:0]  wrPtr;
    logic [ptrBits-1:0]  rdPtr;
    logic [4:0]          count;
    logic                doPush;
    logic                doPop;

    assign doPush = push && !full;              // Overflow ignored
    assign doPop  = pop && !empty;              // Underflow ignored

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) wrPtr <= wrPtr + 1'b1;  // Wraps at the depth
            if (doPop)  rdPtr <= rdPtr + 1'b1;
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
        end
    end

    assign popData = mem[rdPtr];                // Head, read without latency
    assign full    = (count == 5'(fifoDepth));
    assign empty   = (count == '0);
    assign level   = count;

endmodule

// ==== verilog/dacSerializer.sv ====
// DAC serializer: pops pairs, converts both channels to float and shifts them out

`timescale 1ns/100ps

module dacSerializer #(
    parameter int clkDiv = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                empty,
    input  dacPkg::stereoPair_t popData,
    input  logic                mute,
    output logic                pop,
    output logic                dacClk,
    output logic                sd,
    output logic                ws
);

    localparam int divBits = (clkDiv > 1) ? $clog2(clkDiv) : 1;
    localparam int bitBits = $clog2(dacPkg::frameBits);

    dacPkg::stereoPair_t          srcPair;      // Zeroed when muted
    dacPkg::floatWord_t           leftFlt;
    dacPkg::floatWord_t           rightFlt;
    logic [dacPkg::frameBits-1:0] frameWord;
    logic [dacPkg::frameBits-1:0] shiftReg;
    logic [divBits-1:0]           divCnt;
    logic [bitBits-1:0]           bitCnt;       // Bit being driven
    logic [bitBits-1:0]           nextBit;
    logic                         busy;
    logic                         divWrap;
    logic                         fallEdge;
    logic                         frameLast;

    ////////////////////////////////////////////////////////////////////////////
    // Conversion
    ////////////////////////////////////////////////////////////////////////////

    assign srcPair = mute ? '0 : popData;       // Zero gives man 0, exp 1

    lin2exp leftConv (
        .lin (srcPair.left),
        .flt (leftFlt)
    );

    lin2exp rightConv (
        .lin (srcPair.right),
        .flt (rightFlt)
    );

    assign frameWord = {{dacPkg::slotPad{1'b0}}, leftFlt,
                        {dacPkg::slotPad{1'b0}}, rightFlt};

    ////////////////////////////////////////////////////////////////////////////
    // Bit clock and shifter
    ////////////////////////////////////////////////////////////////////////////

    assign divWrap   = (divCnt == divBits'(clkDiv - 1));
    assign fallEdge  = busy && divWrap && dacClk;
    assign nextBit   = bitCnt + 1'b1;           // Wraps to 0 after the frame
    assign frameLast = fallEdge && (bitCnt == bitBits'(dacPkg::frameBits - 1));
    assign pop       = (!busy || frameLast) && !empty;  // Back to back frames
    assign sd        = shiftReg[dacPkg::frameBits-1];   // MSB first

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            dacClk   <= 1'b0;
            ws       <= 1'b0;
            divCnt   <= '0;
            bitCnt   <= '0;
            shiftReg <= '0;
        end else if (pop) begin
            busy     <= 1'b1;                   // Frame starts next cycle
            dacClk   <= 1'b0;
            ws       <= 1'b0;                   // Left slot first
            divCnt   <= '0;
            bitCnt   <= '0;
            shiftReg <= frameWord;              // Mute latched with the words
        end else if (busy) begin
            if (divWrap) begin
                divCnt <= '0;
                dacClk <= !dacClk;
                if (dacClk) begin               // Falling edge moves the data
                    bitCnt   <= nextBit;
                    shiftReg <= shiftReg << 1;
                    ws       <= (nextBit >= bitBits'(dacPkg::slotBits));
                    if (frameLast) begin
                        busy <= 1'b0;           // Nothing queued, clock parks low
                    end
                end
            end else begin
                divCnt <= divCnt + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/dacOutTop.sv ====
// DAC output path top: AXI4-Lite sample slave, pair FIFO and serial DAC link

`timescale 1ns/100ps

module dacOutTop #(
    parameter int fifoDepth = 4,
    parameter int clkDiv    = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  busPkg::axiLiteReq_t req,
    output busPkg::axiLiteRsp_t rsp,
    output logic                dacClk,
    output logic                sd,
    output logic                ws
);

    logic                full;
    logic                empty;
    logic [4:0]          level;
    logic                push;
    logic                pop;
    logic                mute;
    dacPkg::stereoPair_t pushData;
    dacPkg::stereoPair_t popData;

    sampleRegs #(
        .fifoDepth (fifoDepth)
    ) regs (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .rsp      (rsp),
        .full     (full),
        .empty    (empty),
        .level    (level),
        .push     (push),
        .pushData (pushData),
        .mute     (mute)
    );

    sampleFifo #(
        .fifoDepth (fifoDepth)
    ) fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .pushData (pushData),
        .pop      (pop),
        .popData  (popData),
        .full     (full),
        .empty    (empty),
        .level    (level)
    );

    dacSerializer #(
        .clkDiv (clkDiv)
    ) serializer (
        .clk     (clk),
        .rst     (rst),
        .empty   (empty),
        .popData (popData),
        .mute    (mute),
        .pop     (pop),
        .dacClk  (dacClk),
        .sd      (sd),
        .ws      (ws)
    );

endmodule

// ==== verif/clkGen.sv ====
// Testbench clock and reset source: free running clock, reset held for a few cycles

`timescale 1ns/100ps

module clkGen #(
    parameter int period      = 40,
    parameter int resetCycles = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = !clk;       // 50 percent duty
    end

    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #1 rst = 1'b0;                          // Released with the stimulus skew
    end

endmodule

// ==== verif/dacOutChecker.sv ====
// Link and bus checker: deserializes DAC frames and compares frames and responses

`timescale 1ns/100ps

module dacOutChecker (
    input logic                clk,
    input logic                rst,
    input busPkg::axiLiteReq_t req,
    input busPkg::axiLiteRsp_t rsp,
    input logic                dacClk,
    input logic                sd,
    input logic                ws
);

    logic [31:0]      expFrames [$];            // Whole 32-bit frames, left slot first
    busPkg::axiResp_t expBresp  [$];
    busPkg::axiResp_t expRresp  [$];
    logic [31:0]      expRdata  [$];
    logic [31:0]      shiftIn;
    int               bitIdx      = 0;
    int               pending     = 0;          // Frames still to arrive
    int               checks      = 0;
    int               errors      = 0;
    int               testErrors  = 0;
    int               testsRun    = 0;
    int               testsFailed = 0;

    // Smallest exponent whose scaled sample still fits a 10-bit signed mantissa
    function automatic logic [12:0] toFloat(input logic signed [15:0] lin);
        int v;
        int e;
        int m;
        v = lin;
        e = 7;
        for (int k = 7; k >= 1; k--) begin
            if ((v >>> (k - 1)) >= -512 && (v >>> (k - 1)) <= 511) e = k;
        end
        m = (v >>> (e - 1)) & 'h3FF;
        return {m[9:0], e[2:0]};
    endfunction

    task automatic noteError();
        errors++;
        testErrors++;
    endtask

    task automatic expectFrame(input logic [31:0] pair, input logic muted);
        logic [15:0] left;
        logic [15:0] right;
        left  = muted ? 16'h0 : pair[31:16];    // Muted frames carry zero samples
        right = muted ? 16'h0 : pair[15:0];
        expFrames.push_back({3'b000, toFloat(left), 3'b000, toFloat(right)});
        pending++;
    endtask

    task automatic expectWrite(input busPkg::axiResp_t resp);
        expBresp.push_back(resp);
    endtask

    task automatic expectRead(input busPkg::axiResp_t resp, input logic [31:0] data);
        expRresp.push_back(resp);
        expRdata.push_back(data);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Serial link
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge dacClk) begin
        checks++;
        if (ws !== (bitIdx >= 16)) begin
            $display("error ws at frame bit %0d: got %h, expected %h", bitIdx, ws, bitIdx >= 16);
            noteError();
        end
        shiftIn = {shiftIn[30:0], sd};          // MSB arrives first
        bitIdx++;
        if (bitIdx == 32) begin
            bitIdx = 0;
            if (expFrames.size() == 0) begin
                $display("A frame %h came out on the link with none queued", shiftIn);
                noteError();
            end else begin
                checks++;
                pending--;
                if (shiftIn !== expFrames[0]) begin
                    $display("error sd word: got %h, expected %h", shiftIn, expFrames[0]);
                    noteError();
                end
                void'(expFrames.pop_front());
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus responses, sampled mid cycle before the accepting edge
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        // AW and W are taken together and only with both valids up
        if (!rst && (rsp.awready || rsp.wready)) begin
            checks++;
            if ({rsp.awready, rsp.wready} !== {2{req.awvalid && req.wvalid}}) begin
                $display("error awready/wready: got %h, expected %h",
                         {rsp.awready, rsp.wready}, {2{req.awvalid && req.wvalid}});
                noteError();
            end
        end
        if (!rst && rsp.bvalid && req.bready) begin
            if (expBresp.size() == 0) begin
                $display("A write response came back with no write outstanding");
                noteError();
            end else begin
                checks++;
                if (rsp.bresp !== expBresp[0]) begin
                    $display("error bresp: got %h, expected %h", rsp.bresp, expBresp[0]);
                    noteError();
                end
                void'(expBresp.pop_front());
            end
        end
        if (!rst && rsp.rvalid && req.rready) begin
            if (expRresp.size() == 0) begin
                $display("A read response came back with no read outstanding");
                noteError();
            end else begin
                checks += 2;
                if (rsp.rresp !== expRresp[0]) begin
                    $display("error rresp: got %h, expected %h", rsp.rresp, expRresp[0]);
                    noteError();
                end
                if (rsp.rdata !== expRdata[0]) begin
                    $display("error rdata: got %h, expected %h", rsp.rdata, expRdata[0]);
                    noteError();
                end
                void'(expRresp.pop_front());
                void'(expRdata.pop_front());
            end
        end
    end

    // One line per finished table row
    task automatic endTest(input int idx, input string label);
        testsRun++;
        if (testErrors == 0) begin
            $display("test %0d %s: ok", idx, label);
        end else begin
            $display("test %0d %s: %0d errors", idx, label, testErrors);
            testsFailed++;
        end
        testErrors = 0;
    endtask

    task automatic finalCheck();
        if (expFrames.size() + expBresp.size() + expRresp.size() != 0) begin
            $display("%0d frames and %0d responses were expected but never arrived",
                     expFrames.size(), expBresp.size() + expRresp.size());
            errors++;
        end
    endtask

endmodule

// ==== verif/dacOut_asserts.sv ====
// Protocol assertions on the AXI4-Lite responses, the FIFO push and the serial link

`timescale 1ns/100ps

module dacOutAsserts (
    input logic                clk,
    input logic                rst,
    input busPkg::axiLiteReq_t req,
    input busPkg::axiLiteRsp_t rsp,
    input logic                dacClk,
    input logic                ws,
    input logic                push,
    input logic                full
);

    int fails = 0;                              // Count of failed assertions

    // Responses stay up until the master takes them
    assert property (@(posedge clk) disable iff (rst)
        rsp.bvalid && !req.bready |=> rsp.bvalid)
        else begin
            $error("bvalid dropped before bready");
            fails++;
        end

    assert property (@(posedge clk) disable iff (rst)
        rsp.rvalid && !req.rready |=> rsp.rvalid)
        else begin
            $error("rvalid dropped before rready");
            fails++;
        end

    // Channel select moves only with the falling bit clock
    assert property (@(posedge clk) disable iff (rst)
        (ws != $past(ws)) |-> (!dacClk && $past(dacClk)))
        else begin
            $error("ws changed inside a slot");
            fails++;
        end

    assert property (@(posedge clk) disable iff (rst) !(push && full))
        else begin
            $error("push while the FIFO is full");
            fails++;
        end

endmodule

bind dacOutTop dacOutAsserts asserts (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .rsp    (rsp),
    .dacClk (dacClk),
    .ws     (ws),
    .push   (push),
    .full   (full)
);

// ==== verif/dacOutTb.sv ====
// DAC output path testbench: table driven AXI4-Lite stimulus with a watchdog and summary

`timescale 1ns/100ps

module dacOutTb;

    localparam int clkPeriod = 40;
    localparam int fifoDepth = 4;
    localparam int clkDiv    = 2;

    localparam logic [1:0] kWrite = 2'd0;
    localparam logic [1:0] kRead  = 2'd1;
    localparam logic [1:0] kBurst = 2'd2;           // Random sample pairs back to back

    typedef struct packed {
        logic [1:0]       kind;
        busPkg::axiAddr_t addr;
        logic [31:0]      data;                     // Write data or expected read data
        busPkg::axiResp_t resp;
        logic [7:0]       count;                    // Pairs in a burst
    } row_t;

    logic                clk;
    logic                rst;
    busPkg::axiLiteReq_t req;
    busPkg::axiLiteRsp_t rsp;
    logic                dacClk;
    logic                sd;
    logic                ws;
    row_t                tbl [$];
    logic                muted;
    logic [31:0]         randPair;
    longint              limitNs = 0;

    clkGen #(.period(clkPeriod), .resetCycles(2)) clockSrc (.clk(clk), .rst(rst));

    dacOutTop #(
        .fifoDepth (fifoDepth),
        .clkDiv    (clkDiv)
    ) DUT (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .rsp    (rsp),
        .dacClk (dacClk),
        .sd     (sd),
        .ws     (ws)
    );

    dacOutChecker chk (
        .clk (clk), .rst (rst), .req (req), .rsp (rsp),
        .dacClk (dacClk), .sd (sd), .ws (ws)
    );

    task automatic addRow(input logic [1:0] kind, input busPkg::axiAddr_t addr,
                          input logic [31:0] data, input busPkg::axiResp_t resp,
                          input int count);
        tbl.push_back({kind, addr, data, resp, 8'(count)});
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////////

    task automatic buildTable();
        addRow(kRead,  busPkg::addrStatus, 32'h0000_0100, busPkg::respOkay, 0);  // Idle
        // Exponent boundaries, positive then negative
        addRow(kWrite, busPkg::addrSample, 32'h01FF_0200, busPkg::respOkay, 0);
        addRow(kWrite, busPkg::addrSample, 32'h03FF_0400, busPkg::respOkay, 0);
        addRow(kWrite, busPkg::addrSample, 32'h07FF_0800, busPkg::respOkay, 0);
        addRow(kWrite, busPkg::addrSample, 32'h0FFF_1000, busPkg::respOkay, 0);
        addRow(kWrite, busPkg::addrSample, 32'h1FFF_2000, busPkg::respOkay, 0);
        addRow(kWrite, busPkg::addrSample, 32'h3FFF_4000, busPkg::respOkay, 0);
        addRow(kWrite, busPkg::addrSample, 32'hFE00_FDFF, busPkg::respOkay, 0);
        addRow(kWrite, busPkg::addrSample, 32'hFC00_FBFF, busPkg::respOkay, 0);
        addRow(kWrite, busPkg::addrSample, 32'hF800_F7FF, busPkg::respOkay, 0);
        addRow(kWrite, busPkg::addrSample, 32'hF000_EFFF, busPkg::respOkay, 0);
        addRow(kWrite, busPkg::addrSample, 32'hE000_DFFF, busPkg::respOkay, 0);
        addRow(kWrite, busPkg::addrSample, 32'hC000_BFFF, busPkg::respOkay, 0);
        addRow(kWrite, busPkg::addrSample, 32'h0000_FFFF, busPkg::respOkay, 0);
        addRow(kWrite, busPkg::addrSample, 32'h7FFF_8000, busPkg::respOkay, 0);
        // Mute on, readback, muted frame, mute off
        addRow(kWrite, busPkg::addrCtrl,   32'h0000_0001, busPkg::respOkay, 0);
        addRow(kRead,  busPkg::addrCtrl,   32'h0000_0001, busPkg::respOkay, 0);
        addRow(kWrite, busPkg::addrSample, 32'h1234_EDCC, busPkg::respOkay, 0);
        addRow(kWrite, busPkg::addrCtrl,   32'h0000_0000, busPkg::respOkay, 0);
        addRow(kRead,  busPkg::addrCtrl,   32'h0000_0000, busPkg::respOkay, 0);
        addRow(kWrite, busPkg::addrSample, 32'h1234_EDCC, busPkg::respOkay, 0);
        addRow(kBurst, busPkg::addrSample, 32'h0,         busPkg::respOkay, 10);
        // Unmapped and read only addresses
        addRow(kRead,  4'hC,               32'h0000_0000, busPkg::respSlvErr, 0);
        addRow(kWrite, 4'hC,               32'h0000_0001, busPkg::respSlvErr, 0);
        addRow(kWrite, busPkg::addrStatus, 32'h0000_FFFF, busPkg::respSlvErr, 0);
        addRow(kRead,  busPkg::addrCtrl,   32'h0000_0000, busPkg::respOkay, 0);
        addRow(kRead,  busPkg::addrStatus, 32'h0000_0100, busPkg::respOkay, 0);
    endtask

    function automatic string rowLabel(input row_t r);
        string name;
        case (r.kind)
            kWrite:  name = "write";
            kRead:   name = "read";
            default: name = "burst";
        endcase
        return $sformatf("%s addr 0x%h", name, r.addr);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Bus driver, inputs move 1 ns after the rising edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic busWrite(input busPkg::axiAddr_t addr, input logic [31:0] data);
        logic accepted;
        accepted    = 1'b0;
        req.awaddr  = addr;
        req.wdata   = data;
        req.awvalid = 1'b1;
        req.wvalid  = 1'b1;
        while (!accepted) begin
            @(negedge clk);
            accepted = rsp.awready;             // Stalls while the FIFO is full
            @(posedge clk);
            #1;
        end
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        do @(negedge clk); while (!rsp.bvalid);
        @(posedge clk);                         // Response kept waiting one cycle
        #1;
        req.bready = 1'b1;
        @(posedge clk);
        #1;
        req.bready = 1'b0;
    endtask

    task automatic busRead(input busPkg::axiAddr_t addr);
        logic accepted;
        accepted    = 1'b0;
        req.araddr  = addr;
        req.arvalid = 1'b1;
        while (!accepted) begin
            @(negedge clk);
            accepted = rsp.arready;
            @(posedge clk);
            #1;
        end
        req.arvalid = 1'b0;
        do @(negedge clk); while (!rsp.rvalid);
        @(posedge clk);                         // Data kept waiting one cycle
        #1;
        req.rready = 1'b1;
        @(posedge clk);
        #1;
        req.rready = 1'b0;
    endtask

    initial begin
        longint pairs;
        void'($urandom(50691));
        req       = '0;                         // Ready lines low until a response is due
        muted     = 1'b0;
        buildTable();
        pairs = 0;
        foreach (tbl[i]) begin
            if (tbl[i].kind == kBurst) pairs += tbl[i].count;
            else if (tbl[i].kind == kWrite && tbl[i].addr == busPkg::addrSample) pairs++;
        end
        limitNs = 2 * (pairs * dacPkg::frameBits * 2 * clkDiv * clkPeriod
                       + tbl.size() * 50 * clkPeriod);
        @(posedge clk);
        while (rst) @(posedge clk);
        #1;
        foreach (tbl[i]) begin
            case (tbl[i].kind)
                kWrite: begin
                    if (tbl[i].addr == busPkg::addrSample) chk.expectFrame(tbl[i].data, muted);
                    chk.expectWrite(tbl[i].resp);
                    busWrite(tbl[i].addr, tbl[i].data);
                    if (tbl[i].addr == busPkg::addrCtrl) muted = tbl[i].data[0];
                end
                kRead: begin
                    chk.expectRead(tbl[i].resp, tbl[i].data);
                    busRead(tbl[i].addr);
                end
                default: begin
                    repeat (tbl[i].count) begin
                        randPair = $urandom();
                        chk.expectFrame(randPair, muted);
                        chk.expectWrite(busPkg::respOkay);
                        busWrite(busPkg::addrSample, randPair);
                    end
                end
            endcase
            while (chk.pending != 0) @(posedge clk);   // Let the link drain
            chk.endTest(i, rowLabel(tbl[i]));
        end
        chk.finalCheck();
        $display("tests %0d run, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 chk.testsRun, chk.testsFailed, chk.checks, chk.errors, DUT.asserts.fails);
        if (chk.errors == 0 && DUT.asserts.fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog sized from the queued pairs and the row count
    initial begin
        wait (limitNs > 0);
        #(limitNs);
        $display("Watchdog expired after %0d ns with tests still running", limitNs);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
verilog/dacPkg.sv
verilog/busPkg.sv
verilog/lin2exp.sv
verilog/sampleRegs.sv
verilog/sampleFifo.sv
verilog/dacSerializer.sv
verilog/dacOutTop.sv
verif/clkGen.sv
verif/dacOutChecker.sv
verif/dacOut_asserts.sv
verif/dacOutTb.sv

// ==== Bender.yml ====
package:
  name: dacOut

sources:
  - verilog/dacPkg.sv
  - verilog/busPkg.sv
  - verilog/lin2exp.sv
  - verilog/sampleRegs.sv
  - verilog/sampleFifo.sv
  - verilog/dacSerializer.sv
  - verilog/dacOutTop.sv
  - target: simulation
    files:
      - verif/clkGen.sv
      - verif/dacOutChecker.sv
      - verif/dacOut_asserts.sv
      - verif/dacOutTb.sv
